/* design/mul_pkg.sv */
package mul_pkg;

        // Operand width used when the top level is left at its default.
        // Must be even, each operand is split into two halves.
        parameter int MUL_DATA_W = 32;

        // Bit 0 selects the high half of the result.
        // Bit 1 selects signed operands.
        typedef enum logic [1:0]
        {
                UMLALL = 2'b00,
                UMLALH = 2'b01,
                SMLALL = 2'b10,
                SMLALH = 2'b11
        } mul_op_e;

endpackage

/* design/mul_op_if.sv */
`timescale 1ns/10ps

// Decoded operation, issued once per request.
interface mul_op_if #(
        parameter int DATA_W = mul_pkg::MUL_DATA_W
);

        logic                  valid;
        logic                  sign;
        logic                  higher;
        logic [DATA_W-1:0]     op_a;
        logic [DATA_W-1:0]     op_b;
        logic [2*DATA_W-1:0]   acc;

        modport dec (
                output valid, sign, higher, op_a, op_b, acc
        );

        modport exe (
                input  valid, sign, higher, op_a, op_b, acc
        );

endinterface

/* design/mul_prod_if.sv */
`timescale 1ns/10ps

// Finished 64-bit sum with the half select that travels along with it.
interface mul_prod_if #(
        parameter int DATA_W = mul_pkg::MUL_DATA_W
);

        logic                  valid;
        logic [2*DATA_W-1:0]   sum;
        logic                  higher;

        modport exe (
                output valid, sum, higher
        );

        modport res (
                input  valid, sum, higher
        );

endinterface

/* design/mul_decode.sv */
`timescale 1ns/10ps

module mul_decode #(
        parameter int DATA_W = mul_pkg::MUL_DATA_W
) (
        input  logic                  i_clk,
        input  logic                  i_reset,
        input  logic                  i_flush,
        input  logic                  i_req,
        input  mul_pkg::mul_op_e      i_op,
        input  logic [DATA_W-1:0]     i_rm,
        input  logic [DATA_W-1:0]     i_rs,
        input  logic [DATA_W-1:0]     i_rn,
        input  logic [DATA_W-1:0]     i_rh,
        input  logic                  i_cc_pass,
        mul_op_if.dec                 o_op
);

        import mul_pkg::*;

        logic                  armed_q;
        logic                  valid_q;
        logic                  capture;
        logic                  sign_q;
        logic                  higher_q;
        logic [DATA_W-1:0]     op_a_q;
        logic [DATA_W-1:0]     op_b_q;
        logic [2*DATA_W-1:0]   acc_q;

        // A level request issues only once, until it is seen low again.
        assign capture = i_req && !armed_q;

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        armed_q <= 1'b0;
                        valid_q <= 1'b0;
                end
                else
                begin
                        valid_q <= capture && !i_flush;
                        if (capture)
                                armed_q <= 1'b1;
                        else if (!i_req)
                                armed_q <= 1'b0;
                end
        end

        // Failed condition gives zero operands, so the sum is just the accumulator.
        always_ff @(posedge i_clk)
        begin
                if (capture)
                begin
                        sign_q   <= (i_op == SMLALL) || (i_op == SMLALH);
                        higher_q <= (i_op == UMLALH) || (i_op == SMLALH);
                        op_a_q   <= i_cc_pass ? i_rm : '0;
                        op_b_q   <= i_cc_pass ? i_rs : '0;
                        acc_q    <= {i_rh, i_rn};
                end
        end

        assign o_op.valid  = valid_q;
        assign o_op.sign   = sign_q;
        assign o_op.higher = higher_q;
        assign o_op.op_a   = op_a_q;
        assign o_op.op_b   = op_b_q;
        assign o_op.acc    = acc_q;

endmodule

/* design/mul_execute.sv */
`timescale 1ns/10ps

module mul_execute #(
        parameter int DATA_W = mul_pkg::MUL_DATA_W
) (
        input  logic                  i_clk,
        input  logic                  i_reset,
        input  logic                  i_flush,
        input  logic                  i_stall,
        mul_op_if.exe                 i_op,
        mul_prod_if.exe               o_prod
);

        localparam int HALF_W = DATA_W / 2;

        typedef enum logic [2:0]
        {
                S_LOAD,
                S_LL,
                S_HH,
                S_HL,
                S_LH
        } state_e;

        state_e                       state_q;
        logic                         valid_q;
        logic [2*DATA_W-1:0]          acc_q;
        logic [2*DATA_W-1:0]          addend;
        logic [DATA_W-1:0]            a_q;
        logic [DATA_W-1:0]            b_q;
        logic                         sign_q;
        logic                         higher_q;
        logic signed [HALF_W:0]       a_hi;
        logic signed [HALF_W:0]       a_lo;
        logic signed [HALF_W:0]       b_hi;
        logic signed [HALF_W:0]       b_lo;
        logic signed [HALF_W:0]       mul_x;
        logic signed [HALF_W:0]       mul_y;
        logic signed [DATA_W+1:0]     prod;

        function automatic logic [2*DATA_W-1:0] sext(input logic [DATA_W+1:0] p);
                return {{(DATA_W-2){p[DATA_W+1]}}, p};
        endfunction

        // Upper halves carry the sign, lower halves are always unsigned.
        assign a_hi = {sign_q & a_q[DATA_W-1], a_q[DATA_W-1:HALF_W]};
        assign b_hi = {sign_q & b_q[DATA_W-1], b_q[DATA_W-1:HALF_W]};
        assign a_lo = {1'b0, a_q[HALF_W-1:0]};
        assign b_lo = {1'b0, b_q[HALF_W-1:0]};

        // One shared multiplier, operands picked by the current step.
        always_comb
        begin
                mul_x  = '0;
                mul_y  = '0;
                addend = '0;
                case (state_q)
                S_LL:
                begin
                        mul_x  = a_lo;
                        mul_y  = b_lo;
                        addend = sext(prod);
                end
                S_HH:
                begin
                        mul_x  = a_hi;
                        mul_y  = b_hi;
                        addend = sext(prod) << DATA_W;
                end
                S_HL:
                begin
                        mul_x  = a_hi;
                        mul_y  = b_lo;
                        addend = sext(prod) << HALF_W;
                end
                S_LH:
                begin
                        mul_x  = a_lo;
                        mul_y  = b_hi;
                        addend = sext(prod) << HALF_W;
                end
                default:
                begin
                        addend = '0;
                end
                endcase
        end

        assign prod = mul_x * mul_y;

        // Idle has no sequence to freeze, so a stall never loses an issued operation.
        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_flush)
                begin
                        state_q <= S_LOAD;
                        valid_q <= 1'b0;
                        acc_q   <= '0;
                end
                else
                begin
                        valid_q <= 1'b0;
                        if (state_q == S_LOAD)
                        begin
                                if (i_op.valid)
                                begin
                                        acc_q   <= i_op.acc;
                                        state_q <= S_LL;
                                end
                        end
                        else if (!i_stall)
                        begin
                                acc_q <= acc_q + addend;
                                case (state_q)
                                S_LL:    state_q <= S_HH;
                                S_HH:    state_q <= S_HL;
                                S_HL:    state_q <= S_LH;
                                default: state_q <= S_LOAD;
                                endcase
                                valid_q <= (state_q == S_LH);
                        end
                end
        end

        always_ff @(posedge i_clk)
        begin
                if (state_q == S_LOAD && i_op.valid)
                begin
                        a_q      <= i_op.op_a;
                        b_q      <= i_op.op_b;
                        sign_q   <= i_op.sign;
                        higher_q <= i_op.higher;
                end
        end

        assign o_prod.valid  = valid_q;
        assign o_prod.sum    = acc_q;
        assign o_prod.higher = higher_q;

endmodule

/* design/mul_result.sv */
`timescale 1ns/10ps

module mul_result #(
        parameter int DATA_W = mul_pkg::MUL_DATA_W
) (
        input  logic                  i_clk,
        input  logic                  i_reset,
        input  logic                  i_flush,
        input  logic                  i_req,
        mul_prod_if.res               i_prod,
        output logic                  o_ack,
        output logic [DATA_W-1:0]     o_rd
);

        logic                  ack_q;
        logic [DATA_W-1:0]     rd_q;
        logic [DATA_W-1:0]     half;

        assign half = i_prod.higher ? i_prod.sum[2*DATA_W-1:DATA_W]
                                    : i_prod.sum[DATA_W-1:0];

        // Ack rises with the result and falls once the request is withdrawn.
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        ack_q <= 1'b0;
                        rd_q  <= '0;
                end
                else if (i_flush)
                begin
                        ack_q <= 1'b0;
                end
                else if (i_prod.valid)
                begin
                        ack_q <= 1'b1;
                        rd_q  <= half;
                end
                else if (!i_req)
                begin
                        ack_q <= 1'b0;
                end
        end

        // rd keeps the last result after ack drops
        assign o_ack = ack_q;
        assign o_rd  = rd_q;

endmodule

/* design/mul_top.sv */
`timescale 1ns/10ps

module mul_top #(
        parameter int DATA_W = mul_pkg::MUL_DATA_W
) (
        input  logic                  i_clk,
        input  logic                  i_reset,
        input  logic                  i_req,
        input  mul_pkg::mul_op_e      i_op,
        input  logic [DATA_W-1:0]     i_rm,
        input  logic [DATA_W-1:0]     i_rs,
        input  logic [DATA_W-1:0]     i_rn,
        input  logic [DATA_W-1:0]     i_rh,
        input  logic                  i_cc_pass,
        input  logic                  i_stall,
        input  logic                  i_flush,
        output logic                  o_ack,
        output logic [DATA_W-1:0]     o_rd
);

        mul_op_if   #(.DATA_W(DATA_W)) op_bus ();
        mul_prod_if #(.DATA_W(DATA_W)) prod_bus ();

        mul_decode #(.DATA_W(DATA_W)) u_decode (
                .i_clk     (i_clk),
                .i_reset   (i_reset),
                .i_flush   (i_flush),
                .i_req     (i_req),
                .i_op      (i_op),
                .i_rm      (i_rm),
                .i_rs      (i_rs),
                .i_rn      (i_rn),
                .i_rh      (i_rh),
                .i_cc_pass (i_cc_pass),
                .o_op      (op_bus.dec)
        );

        // Only this stage sees the stall.
        mul_execute #(.DATA_W(DATA_W)) u_execute (
                .i_clk     (i_clk),
                .i_reset   (i_reset),
                .i_flush   (i_flush),
                .i_stall   (i_stall),
                .i_op      (op_bus.exe),
                .o_prod    (prod_bus.exe)
        );

        mul_result #(.DATA_W(DATA_W)) u_result (
                .i_clk     (i_clk),
                .i_reset   (i_reset),
                .i_flush   (i_flush),
                .i_req     (i_req),
                .i_prod    (prod_bus.res),
                .o_ack     (o_ack),
                .o_rd      (o_rd)
        );

endmodule

/* dv/mul_tb.sv */
`timescale 1ns/10ps

module mul_tb;

        import mul_pkg::*;

        localparam int W = 32;

        typedef struct packed
        {
                mul_op_e        op;
                logic [W-1:0]   rm;
                logic [W-1:0]   rs;
                logic [W-1:0]   rn;
                logic [W-1:0]   rh;
                logic           cc;
                logic           stall;
                logic           flush;
                logic [W-1:0]   rd_exp;
        } row_t;

        logic           i_clk;
        logic           i_reset;
        logic           i_req;
        mul_op_e        i_op;
        logic [W-1:0]   i_rm;
        logic [W-1:0]   i_rs;
        logic [W-1:0]   i_rn;
        logic [W-1:0]   i_rh;
        logic           i_cc_pass;
        logic           i_stall;
        logic           i_flush;
        logic           o_ack;
        logic [W-1:0]   o_rd;

        row_t           rows[$];
        integer         seed;
        int             pass_cnt;
        int             fail_cnt;

        mul_top #(.DATA_W(W)) UUT (
                .i_clk     (i_clk),
                .i_reset   (i_reset),
                .i_req     (i_req),
                .i_op      (i_op),
                .i_rm      (i_rm),
                .i_rs      (i_rs),
                .i_rn      (i_rn),
                .i_rh      (i_rh),
                .i_cc_pass (i_cc_pass),
                .i_stall   (i_stall),
                .i_flush   (i_flush),
                .o_ack     (o_ack),
                .o_rd      (o_rd)
        );

        always
        begin
                #2 i_clk = ~i_clk;
        end

        // Full 64-bit rm * rs + {rh, rn}, then the half picked by op bit 0.
        function automatic logic [W-1:0] ref_mac(input row_t r);
                logic [2*W-1:0] a;
                logic [2*W-1:0] b;
                logic [2*W-1:0] sum;
                a = r.op[1] ? {{W{r.rm[W-1]}}, r.rm} : {{W{1'b0}}, r.rm};
                b = r.op[1] ? {{W{r.rs[W-1]}}, r.rs} : {{W{1'b0}}, r.rs};
                if (!r.cc)
                begin
                        a = '0;
                        b = '0;
                end
                sum = a * b + {r.rh, r.rn};
                return r.op[0] ? sum[2*W-1:W] : sum[W-1:0];
        endfunction

        task automatic add_row(input mul_op_e op, input logic [W-1:0] rm, input logic [W-1:0] rs,
                               input logic [W-1:0] rn, input logic [W-1:0] rh, input logic cc,
                               input logic stall, input logic flush);
                row_t r;
                r = '{op, rm, rs, rn, rh, cc, stall, flush, '0};
                r.rd_exp = ref_mac(r);
                rows.push_back(r);
        endtask

        // Steps on falling edges until o_ack reaches the level or the limit runs out.
        // With inject set, the row's stall and flush pulses are driven on the way.
        task automatic wait_ack(input logic level, input int limit, input logic inject,
                                input row_t r, output logic ok);
                int n;
                ok = 1'b0;
                n = 0;
                while (!ok && n < limit)
                begin
                        @(negedge i_clk);
                        n++;
                        i_stall = inject && r.stall && n <= 3;
                        i_flush = inject && r.flush && n == 2;
                        ok = (o_ack === level);
                end
                i_stall = 1'b0;
                i_flush = 1'b0;
        endtask

        initial
        begin
                logic        row_ok;
                logic        got;
                logic [31:0] rnd;
                seed = 32'h2b30;
                pass_cnt = 0;
                fail_cnt = 0;
                i_clk = 1'b0;
                i_reset = 1'b1;
                i_req = 1'b0;
                i_op = UMLALL;
                i_rm = '0;
                i_rs = '0;
                i_rn = '0;
                i_rh = '0;
                i_cc_pass = 1'b1;
                i_stall = 1'b0;
                i_flush = 1'b0;

                add_row(UMLALL, 32'hffffffff, 32'hffffffff, 32'h0, 32'h0, 1, 0, 0);
                add_row(UMLALH, 32'hffffffff, 32'hffffffff, 32'h0, 32'h0, 1, 0, 0);
                add_row(UMLALH, 32'h00000001, 32'h00000001, 32'hffffffff, 32'h0, 1, 0, 0);
                add_row(UMLALL, 32'h12345678, 32'h9abcdef0, 32'h11111111, 32'h22222222, 1, 0, 0);
                add_row(SMLALL, 32'h80000000, 32'h80000000, 32'h0, 32'h0, 1, 0, 0);
                add_row(SMLALH, 32'h80000000, 32'h80000000, 32'h0, 32'h0, 1, 0, 0);
                add_row(SMLALH, 32'hffffffff, 32'h00000003, 32'h0, 32'h0, 1, 0, 0);
                add_row(SMLALL, 32'h80000000, 32'h7fffffff, 32'h5, 32'hffffffff, 1, 0, 0);
                add_row(SMLALH, 32'hfffffffe, 32'h7fffffff, 32'h1, 32'h0, 1, 0, 0);
                add_row(UMLALL, 32'hdeadbeef, 32'h12345678, 32'hcafef00d, 32'h0badf00d, 0, 0, 0);
                add_row(SMLALH, 32'hdeadbeef, 32'h12345678, 32'hcafef00d, 32'h0badf00d, 0, 0, 0);
                add_row(UMLALH, 32'hfedcba98, 32'h76543210, 32'h0, 32'h1, 1, 1, 0);
                add_row(SMLALL, 32'h80000001, 32'hffffffff, 32'h7, 32'h7, 1, 1, 0);
                add_row(UMLALH, 32'hffffffff, 32'h00000002, 32'h3, 32'h4, 1, 0, 1);
                add_row(SMLALH, 32'h80000000, 32'h00000002, 32'h9, 32'h8, 1, 0, 1);
                for (int k = 0; k < 8; k++)
                begin
                        rnd = $random(seed);
                        add_row(mul_op_e'(rnd[1:0]), $random(seed), $random(seed),
                                $random(seed), $random(seed), |rnd[3:2], rnd[4], 1'b0);
                end

                repeat (8) @(negedge i_clk);
                i_reset = 1'b0;

                // Nothing has been requested yet.
                @(negedge i_clk);
                row_ok = 1'b1;
                if (o_ack !== 1'b0)
                begin
                        $display("FAIL %0t o_ack expected 0 actual %b", $time, o_ack);
                        row_ok = 1'b0;
                end
                if (o_rd !== {W{1'b0}})
                begin
                        $display("FAIL %0t o_rd expected %h actual %h", $time, {W{1'b0}}, o_rd);
                        row_ok = 1'b0;
                end
                if (row_ok)
                        pass_cnt++;
                else
                        fail_cnt++;
                $display("test reset %s", row_ok ? "ok" : "failed");

                foreach (rows[i])
                begin
                        row_ok = 1'b1;
                        i_op = rows[i].op;
                        i_rm = rows[i].rm;
                        i_rs = rows[i].rs;
                        i_rn = rows[i].rn;
                        i_rh = rows[i].rh;
                        i_cc_pass = rows[i].cc;
                        i_req = 1'b1;
                        if (rows[i].flush)
                        begin
                                wait_ack(1'b1, 20, 1'b1, rows[i], got);
                                if (got)
                                begin
                                        $display("test %0d: o_ack was raised after a flush", i);
                                        row_ok = 1'b0;
                                end
                                // Decode is still armed, so the request goes low once.
                                i_req = 1'b0;
                                @(negedge i_clk);
                                i_req = 1'b1;
                        end
                        wait_ack(1'b1, 40, !rows[i].flush, rows[i], got);
                        if (!got)
                        begin
                                $display("test %0d: timed out waiting for o_ack to rise", i);
                                row_ok = 1'b0;
                        end
                        else if (o_rd !== rows[i].rd_exp)
                        begin
                                $display("FAIL %0t o_rd expected %h actual %h",
                                         $time, rows[i].rd_exp, o_rd);
                                row_ok = 1'b0;
                        end
                        i_req = 1'b0;
                        wait_ack(1'b0, 10, 1'b0, rows[i], got);
                        if (!got)
                        begin
                                $display("test %0d: timed out waiting for o_ack to fall", i);
                                row_ok = 1'b0;
                        end
                        if (row_ok)
                                pass_cnt++;
                        else
                                fail_cnt++;
                        $display("test %0d %s %s", i, i_op.name(), row_ok ? "ok" : "failed");
                end

                $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
                if (fail_cnt == 0)
                        $display("PASS: all tests");
                else
                        $display("FAIL: see errors above");
                $finish;
        end

endmodule

/* flist.f */
design/mul_pkg.sv
design/mul_op_if.sv
design/mul_prod_if.sv
design/mul_decode.sv
design/mul_execute.sv
design/mul_result.sv
design/mul_top.sv
dv/mul_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing -j 0
TOP       = mul_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# The simulation passes only if the log holds the pass message.
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
